// ==== include/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath and field widths
`define CPU_WORD_W 16
`define CPU_REG_W  3
`define CPU_OP_W   5
`define CPU_FN_W   2
`define CPU_IMM_W  5

// Opcodes
`define CPU_OP_HALT 5'b00000
`define CPU_OP_NOP  5'b00001
`define CPU_OP_ADDI 5'b01000
`define CPU_OP_LD   5'b10001
`define CPU_OP_ST   5'b10000
`define CPU_OP_ALU  5'b11011

// Function field of the register-register ALU opcode
`define CPU_FN_ADD 2'b00
`define CPU_FN_SUB 2'b01
`define CPU_FN_XOR 2'b10
`define CPU_FN_AND 2'b11

// Operand forwarding selects
`define CPU_FWD_W     2
`define CPU_FWD_NONE  2'b00
`define CPU_FWD_EXMEM 2'b01
`define CPU_FWD_MEMWB 2'b10

// Data memory words
`define CPU_DMEM_DEPTH 64

`endif

// ==== rtl/cpu_pkg.sv ====
`include "cpu_macros.svh"

package cpuPkg;

   // Register-register layout
   typedef struct packed {
      logic [`CPU_OP_W-1:0]  opcode;
      logic [`CPU_REG_W-1:0] rs;
      logic [`CPU_REG_W-1:0] rt;
      logic [`CPU_REG_W-1:0] rd;
      logic [`CPU_FN_W-1:0]  fn;
   } rFormT;

   // Immediate layout, rd sits where rForm has rt
   typedef struct packed {
      logic [`CPU_OP_W-1:0]  opcode;
      logic [`CPU_REG_W-1:0] rs;
      logic [`CPU_REG_W-1:0] rd;
      logic [`CPU_IMM_W-1:0] imm;
   } iFormT;

   typedef union packed {
      rFormT rForm;
      iFormT iForm;
   } instrWordT;

   typedef enum logic [`CPU_FN_W-1:0] {
      fnAdd = `CPU_FN_ADD,
      fnSub = `CPU_FN_SUB,
      fnXor = `CPU_FN_XOR,
      fnAnd = `CPU_FN_AND
   } aluFnT;

   typedef struct packed {
      logic                   valid;
      instrWordT              instr;
      logic [`CPU_WORD_W-1:0] pcPlus2;
   } ifIdT;

   typedef struct packed {
      logic                   valid;
      logic                   illegal;
      logic                   isLoad;
      logic                   isStore;
      logic                   regWrite;
      logic                   useImm;
      aluFnT                  aluFn;
      logic [`CPU_REG_W-1:0]  srcA;
      logic [`CPU_REG_W-1:0]  srcB;
      logic [`CPU_REG_W-1:0]  dest;
      logic [`CPU_WORD_W-1:0] opA;
      logic [`CPU_WORD_W-1:0] opB;
      logic [`CPU_WORD_W-1:0] imm;
      logic                   halt;
   } idExT;

   typedef struct packed {
      logic                   valid;
      logic                   illegal;
      logic                   isLoad;
      logic                   isStore;
      logic                   regWrite;
      logic [`CPU_REG_W-1:0]  dest;
      logic [`CPU_WORD_W-1:0] aluResult;
      logic [`CPU_WORD_W-1:0] storeData;
      logic                   halt;
   } exMemT;

   typedef struct packed {
      logic                   valid;
      logic                   illegal;
      logic                   regWrite;
      logic [`CPU_REG_W-1:0]  dest;
      logic [`CPU_WORD_W-1:0] wbData;
      logic                   halt;
   } memWbT;

endpackage

// ==== rtl/fetchUnit.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetchUnit (
   input  logic                   clk,
   input  logic                   arstN,
   input  logic                   stall,
   input  logic                   haltSeen,
   input  logic [`CPU_WORD_W-1:0] imemData,
   output logic [`CPU_WORD_W-1:0] imemAddr,
   output cpuPkg::ifIdT           ifId
);

   logic [`CPU_WORD_W-1:0] pc;
   logic [`CPU_WORD_W-1:0] pcPlus2;

   assign pcPlus2  = pc + 'd2;
   assign imemAddr = pc;

   // PC freezes for a load-use stall and for good after a halt
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc <= '0;
      end else if (!stall && !haltSeen) begin
         pc <= pcPlus2;
      end
   end

   // IF/ID, stall holds the current word
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         ifId <= '0;
      end else if (!stall) begin
         ifId.valid   <= !haltSeen;
         ifId.instr   <= imemData;
         ifId.pcPlus2 <= pcPlus2;
      end
   end

   // The bubble behind a load clears the hazard after one cycle
   stallOneCycle: assert property (@(posedge clk) disable iff (!arstN)
      stall |=> !stall)
      else $error("load-use stall lasted more than one cycle");

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module regFile (
   input  logic                   clk,
   input  logic                   arstN,
   input  logic [`CPU_REG_W-1:0]  rdA,
   input  logic [`CPU_REG_W-1:0]  rdB,
   output logic [`CPU_WORD_W-1:0] dataA,
   output logic [`CPU_WORD_W-1:0] dataB,
   input  logic                   wrEn,
   input  logic [`CPU_REG_W-1:0]  wrReg,
   input  logic [`CPU_WORD_W-1:0] wrData
);

   localparam int NumRegs = 1 << `CPU_REG_W;

   logic [`CPU_WORD_W-1:0] regs [NumRegs];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         regs <= '{default: '0};
      end else if (wrEn) begin
         regs[wrReg] <= wrData;
      end
   end

   // Write-through so writeback and decode can share a cycle
   assign dataA = (wrEn && wrReg == rdA) ? wrData : regs[rdA];
   assign dataB = (wrEn && wrReg == rdB) ? wrData : regs[rdB];

endmodule

// ==== rtl/decodeUnit.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decodeUnit (
   input  logic           clk,
   input  logic           arstN,
   input  cpuPkg::ifIdT   ifId,
   input  logic           stall,
   input  cpuPkg::memWbT  memWb,
   output cpuPkg::idExT   idEx,
   output logic           haltSeen
);

   cpuPkg::instrWordT      instr;
   cpuPkg::idExT           idExNext;
   logic [`CPU_REG_W-1:0]  srcA;
   logic [`CPU_REG_W-1:0]  srcB;
   logic [`CPU_WORD_W-1:0] dataA;
   logic [`CPU_WORD_W-1:0] dataB;
   logic [`CPU_WORD_W-1:0] immExt;
   logic                   haltNow;
   logic                   haltReg;

   assign instr = ifId.instr;

   // rt and the I-form rd share bits, so ST store data comes out of port B
   assign srcA = instr.rForm.rs;
   assign srcB = instr.rForm.rt;

   assign immExt = {{(`CPU_WORD_W - `CPU_IMM_W){instr.iForm.imm[`CPU_IMM_W-1]}},
                    instr.iForm.imm};

   regFile regs (
      .clk    (clk),
      .arstN  (arstN),
      .rdA    (srcA),
      .rdB    (srcB),
      .dataA  (dataA),
      .dataB  (dataB),
      .wrEn   (memWb.valid && memWb.regWrite),
      .wrReg  (memWb.dest),
      .wrData (memWb.wbData)
   );

   always_comb begin
      idExNext       = '0;
      idExNext.valid = ifId.valid;
      idExNext.aluFn = cpuPkg::fnAdd;
      idExNext.srcA  = srcA;
      idExNext.srcB  = srcB;
      idExNext.opA   = dataA;
      idExNext.opB   = dataB;
      idExNext.imm   = immExt;
      case (instr.rForm.opcode)
         `CPU_OP_HALT: begin
            idExNext.halt = 1'b1;
         end
         `CPU_OP_NOP: begin
            idExNext.halt = 1'b0;
         end
         `CPU_OP_ADDI: begin
            idExNext.regWrite = 1'b1;
            idExNext.useImm   = 1'b1;
            idExNext.dest     = instr.iForm.rd;
         end
         `CPU_OP_LD: begin
            idExNext.isLoad   = 1'b1;
            idExNext.regWrite = 1'b1;
            idExNext.useImm   = 1'b1;
            idExNext.dest     = instr.iForm.rd;
         end
         // Address from rs plus immediate
         `CPU_OP_ST: begin
            idExNext.isStore = 1'b1;
            idExNext.useImm  = 1'b1;
         end
         `CPU_OP_ALU: begin
            idExNext.regWrite = 1'b1;
            idExNext.dest     = instr.rForm.rd;
            idExNext.aluFn    = cpuPkg::aluFnT'(instr.rForm.fn);
         end
         default: begin
            idExNext.illegal = 1'b1;
         end
      endcase
   end

   // Combinational part lets fetch drop the word behind HALT
   assign haltNow  = ifId.valid && instr.rForm.opcode == `CPU_OP_HALT;
   assign haltSeen = haltReg || haltNow;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         haltReg <= 1'b0;
      end else if (haltNow) begin
         haltReg <= 1'b1;
      end
   end

   // ID/EX, bubble on load-use stall
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         idEx <= '0;
      end else if (stall) begin
         idEx <= '0;
      end else begin
         idEx <= idExNext;
      end
   end

   // Fetch must drop the word that follows HALT
   nothingAfterHalt: assert property (@(posedge clk) disable iff (!arstN)
      (idEx.valid && idEx.halt) |=> !idEx.valid)
      else $error("a valid instruction entered ID/EX right behind HALT");

endmodule

// ==== rtl/hazardUnit.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module hazardUnit (
   input  cpuPkg::ifIdT           ifId,
   input  cpuPkg::idExT           idEx,
   input  cpuPkg::exMemT          exMem,
   input  cpuPkg::memWbT          memWb,
   output logic                   stall,
   output logic [`CPU_FWD_W-1:0]  fwdA,
   output logic [`CPU_FWD_W-1:0]  fwdB
);

   cpuPkg::instrWordT instr;
   logic              readsA;
   logic              readsB;
   logic              hitA;
   logic              hitB;

   // Nearest producer wins, loads in EX/MEM have no data yet
   function automatic logic [`CPU_FWD_W-1:0] fwdSel(input logic [`CPU_REG_W-1:0] src,
                                                    input cpuPkg::exMemT em,
                                                    input cpuPkg::memWbT mw);
      logic [`CPU_FWD_W-1:0] sel;
      sel = `CPU_FWD_NONE;
      if (em.valid && em.regWrite && !em.isLoad && em.dest == src) begin
         sel = `CPU_FWD_EXMEM;
      end else if (mw.valid && mw.regWrite && mw.dest == src) begin
         sel = `CPU_FWD_MEMWB;
      end
      return sel;
   endfunction

   assign instr = ifId.instr;

   // Which register ports the IF/ID word actually reads
   always_comb begin
      readsA = 1'b0;
      readsB = 1'b0;
      case (instr.rForm.opcode)
         `CPU_OP_ALU, `CPU_OP_ST: begin
            readsA = 1'b1;
            readsB = 1'b1;
         end
         `CPU_OP_ADDI, `CPU_OP_LD: begin
            readsA = 1'b1;
         end
         default: begin
            readsA = 1'b0;
         end
      endcase
   end

   assign hitA  = readsA && idEx.dest == instr.rForm.rs;
   assign hitB  = readsB && idEx.dest == instr.rForm.rt;
   assign stall = ifId.valid && idEx.valid && idEx.isLoad && (hitA || hitB);

   assign fwdA = fwdSel(idEx.srcA, exMem, memWb);
   assign fwdB = fwdSel(idEx.srcB, exMem, memWb);

endmodule

// ==== rtl/executeUnit.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module executeUnit (
   input  logic                   clk,
   input  logic                   arstN,
   input  cpuPkg::idExT           idEx,
   input  logic [`CPU_FWD_W-1:0]  fwdA,
   input  logic [`CPU_FWD_W-1:0]  fwdB,
   input  cpuPkg::exMemT          exMem,
   input  cpuPkg::memWbT          memWb,
   output cpuPkg::exMemT          exMemOut
);

   logic [`CPU_WORD_W-1:0] opA;
   logic [`CPU_WORD_W-1:0] opBFwd;
   logic [`CPU_WORD_W-1:0] opB;
   logic [`CPU_WORD_W-1:0] result;

   function automatic logic [`CPU_WORD_W-1:0] pickOperand(
      input logic [`CPU_FWD_W-1:0]  sel,
      input logic [`CPU_WORD_W-1:0] decoded,
      input cpuPkg::exMemT          em,
      input cpuPkg::memWbT          mw);
      logic [`CPU_WORD_W-1:0] value;
      case (sel)
         `CPU_FWD_EXMEM: value = em.aluResult;
         `CPU_FWD_MEMWB: value = mw.wbData;
         default:        value = decoded;
      endcase
      return value;
   endfunction

   assign opA    = pickOperand(fwdA, idEx.opA, exMem, memWb);
   assign opBFwd = pickOperand(fwdB, idEx.opB, exMem, memWb);
   // Forwarded B is still needed as store data
   assign opB    = idEx.useImm ? idEx.imm : opBFwd;

   always_comb begin
      case (idEx.aluFn)
         cpuPkg::fnSub: result = opA - opB;
         cpuPkg::fnXor: result = opA ^ opB;
         cpuPkg::fnAnd: result = opA & opB;
         default:       result = opA + opB;
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         exMemOut <= '0;
      end else begin
         exMemOut.valid     <= idEx.valid;
         exMemOut.illegal   <= idEx.illegal;
         exMemOut.isLoad    <= idEx.isLoad;
         exMemOut.isStore   <= idEx.isStore;
         exMemOut.regWrite  <= idEx.regWrite;
         exMemOut.dest      <= idEx.dest;
         exMemOut.aluResult <= result;
         exMemOut.storeData <= opBFwd;
         exMemOut.halt      <= idEx.halt;
      end
   end

   // A load in EX/MEM only has its address, the stall must keep its reader out
   noLoadForward: assert property (@(posedge clk) disable iff (!arstN)
      (exMem.valid && exMem.isLoad && idEx.valid && (idEx.regWrite || idEx.isStore))
      |-> exMem.dest != idEx.srcA)
      else $error("operand A depends on a load still in EX/MEM");

endmodule

// ==== rtl/memoryUnit.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module memoryUnit (
   input  logic          clk,
   input  logic          arstN,
   input  cpuPkg::exMemT exMem,
   output cpuPkg::memWbT memWb
);

   localparam int AddrW = $clog2(`CPU_DMEM_DEPTH);

   logic [`CPU_WORD_W-1:0] dmem [`CPU_DMEM_DEPTH];
   logic [AddrW-1:0]       addr;
   logic [`CPU_WORD_W-1:0] rdData;
   logic [`CPU_WORD_W-1:0] wbData;

   // Low address bits only, the memory wraps
   assign addr   = exMem.aluResult[AddrW-1:0];
   assign rdData = dmem[addr];

   always_ff @(posedge clk) begin
      if (exMem.valid && exMem.isStore) begin
         dmem[addr] <= exMem.storeData;
      end
   end

   assign wbData = exMem.isLoad ? rdData : exMem.aluResult;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         memWb <= '0;
      end else begin
         memWb.valid    <= exMem.valid;
         memWb.illegal  <= exMem.illegal;
         memWb.regWrite <= exMem.regWrite;
         memWb.dest     <= exMem.dest;
         memWb.wbData   <= wbData;
         memWb.halt     <= exMem.halt;
      end
   end

endmodule

// ==== rtl/cpuTop.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpuTop (
   input  logic                   clk,
   input  logic                   arstN,
   output logic [`CPU_WORD_W-1:0] imemAddr,
   input  logic [`CPU_WORD_W-1:0] imemData,
   output logic                   wbValid,
   output logic [`CPU_REG_W-1:0]  wbReg,
   output logic [`CPU_WORD_W-1:0] wbData,
   output logic                   halted,
   output logic                   err
);

   cpuPkg::ifIdT          ifId;
   cpuPkg::idExT          idEx;
   cpuPkg::exMemT         exMem;
   cpuPkg::memWbT         memWb;
   logic                  stall;
   logic                  haltSeen;
   logic [`CPU_FWD_W-1:0] fwdA;
   logic [`CPU_FWD_W-1:0] fwdB;

   fetchUnit fetch (
      .clk      (clk),
      .arstN    (arstN),
      .stall    (stall),
      .haltSeen (haltSeen),
      .imemData (imemData),
      .imemAddr (imemAddr),
      .ifId     (ifId)
   );

   decodeUnit decode (
      .clk      (clk),
      .arstN    (arstN),
      .ifId     (ifId),
      .stall    (stall),
      .memWb    (memWb),
      .idEx     (idEx),
      .haltSeen (haltSeen)
   );

   hazardUnit hazard (
      .ifId  (ifId),
      .idEx  (idEx),
      .exMem (exMem),
      .memWb (memWb),
      .stall (stall),
      .fwdA  (fwdA),
      .fwdB  (fwdB)
   );

   executeUnit execute (
      .clk      (clk),
      .arstN    (arstN),
      .idEx     (idEx),
      .fwdA     (fwdA),
      .fwdB     (fwdB),
      .exMem    (exMem),
      .memWb    (memWb),
      .exMemOut (exMem)
   );

   memoryUnit memory (
      .clk   (clk),
      .arstN (arstN),
      .exMem (exMem),
      .memWb (memWb)
   );

   // Writeback seen from outside
   assign wbValid = memWb.valid && memWb.regWrite;
   assign wbReg   = memWb.dest;
   assign wbData  = memWb.wbData;
   assign err     = memWb.valid && memWb.illegal;

   // Sticky until reset
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         halted <= 1'b0;
      end else if (memWb.valid && memWb.halt) begin
         halted <= 1'b1;
      end
   end

endmodule

// ==== bench/cpuTb.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpuTb;

   localparam int ClkPeriod   = 20;
   localparam int ResetCycles = 5;
   localparam int HoldCycles  = 8;
   localparam int MaxWords    = 64;
   localparam int MaxEvents   = 32;

   // No instruction uses this opcode
   localparam logic [`CPU_OP_W-1:0]   IllegalOp = 5'b11111;
   localparam logic [`CPU_WORD_W-1:0] NopWord   = {`CPU_OP_NOP, 11'd0};

   // One expected writeback or err strobe
   typedef struct packed {
      logic                   isErr;
      logic [`CPU_REG_W-1:0]  rd;
      logic [`CPU_WORD_W-1:0] data;
   } wbEventT;

   logic                   clk;
   logic                   arstN;
   logic [`CPU_WORD_W-1:0] imemAddr;
   logic [`CPU_WORD_W-1:0] imemData;
   logic                   wbValid;
   logic [`CPU_REG_W-1:0]  wbReg;
   logic [`CPU_WORD_W-1:0] wbData;
   logic                   halted;
   logic                   err;

   logic [`CPU_WORD_W-1:0] prog [MaxWords];
   wbEventT                expTab [MaxEvents];
   string                  expName [MaxEvents];
   logic [`CPU_WORD_W-1:0] refRegs [8];
   logic [`CPU_WORD_W-1:0] refMem [`CPU_DMEM_DEPTH];
   logic [`CPU_WORD_W-1:0] addrHeld;
   logic                   tableReady;
   int                     progLen;
   int                     expCount;
   int                     errors;
   int                     checks;
   int                     idx;

   cpuTop dut (
      .clk      (clk),
      .arstN    (arstN),
      .imemAddr (imemAddr),
      .imemData (imemData),
      .wbValid  (wbValid),
      .wbReg    (wbReg),
      .wbData   (wbData),
      .halted   (halted),
      .err      (err)
   );

   initial clk = 1'b0;
   always #(ClkPeriod / 2) clk = ~clk;

   // Instruction port, the address only moves on a rising edge
   always @(imemAddr or tableReady) begin
      if ((imemAddr >> 1) < progLen) begin
         imemData <= prog[imemAddr >> 1];
      end else begin
         imemData <= NopWord;
      end
   end

   function automatic logic [`CPU_WORD_W-1:0] signExtend(input logic [`CPU_IMM_W-1:0] imm);
      return {{(`CPU_WORD_W - `CPU_IMM_W){imm[`CPU_IMM_W-1]}}, imm};
   endfunction

   function automatic logic [`CPU_WORD_W-1:0] rFormWord(input logic [1:0] fn,
                                                        input logic [2:0] rd,
                                                        input logic [2:0] rs,
                                                        input logic [2:0] rt);
      return {`CPU_OP_ALU, rs, rt, rd, fn};
   endfunction

   function automatic logic [`CPU_WORD_W-1:0] iFormWord(input logic [4:0] op,
                                                        input logic [2:0] rd,
                                                        input logic [2:0] rs,
                                                        input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   task automatic appendWord(input logic [`CPU_WORD_W-1:0] word);
      prog[progLen] = word;
      progLen++;
   endtask

   task automatic recordEvent(input string name, input logic isErr,
                              input logic [2:0] rd, input logic [`CPU_WORD_W-1:0] value);
      expTab[expCount].isErr = isErr;
      expTab[expCount].rd    = rd;
      expTab[expCount].data  = value;
      expName[expCount]      = name;
      expCount++;
   endtask

   task automatic addImmediate(input string name, input logic [2:0] rd,
                               input logic [2:0] rs, input logic [4:0] imm);
      logic [`CPU_WORD_W-1:0] value;
      value       = refRegs[rs] + signExtend(imm);
      refRegs[rd] = value;
      appendWord(iFormWord(`CPU_OP_ADDI, rd, rs, imm));
      recordEvent(name, 1'b0, rd, value);
   endtask

   task automatic aluOp(input string name, input logic [1:0] fn, input logic [2:0] rd,
                        input logic [2:0] rs, input logic [2:0] rt);
      logic [`CPU_WORD_W-1:0] value;
      case (fn)
         `CPU_FN_SUB: value = refRegs[rs] - refRegs[rt];
         `CPU_FN_XOR: value = refRegs[rs] ^ refRegs[rt];
         `CPU_FN_AND: value = refRegs[rs] & refRegs[rt];
         default:     value = refRegs[rs] + refRegs[rt];
      endcase
      refRegs[rd] = value;
      appendWord(rFormWord(fn, rd, rs, rt));
      recordEvent(name, 1'b0, rd, value);
   endtask

   // Store data comes from the I-form rd field
   task automatic storeWord(input logic [2:0] rd, input logic [2:0] rs, input logic [4:0] imm);
      logic [`CPU_WORD_W-1:0] addr;
      addr = refRegs[rs] + signExtend(imm);
      refMem[addr % `CPU_DMEM_DEPTH] = refRegs[rd];
      appendWord(iFormWord(`CPU_OP_ST, rd, rs, imm));
   endtask

   task automatic loadWord(input string name, input logic [2:0] rd,
                           input logic [2:0] rs, input logic [4:0] imm);
      logic [`CPU_WORD_W-1:0] addr;
      addr        = refRegs[rs] + signExtend(imm);
      refRegs[rd] = refMem[addr % `CPU_DMEM_DEPTH];
      appendWord(iFormWord(`CPU_OP_LD, rd, rs, imm));
      recordEvent(name, 1'b0, rd, refRegs[rd]);
   endtask

   task automatic buildProgram();
      progLen  = 0;
      expCount = 0;
      for (int r = 0; r < 8; r++) begin
         refRegs[r] = '0;
      end
      addImmediate("addi_pos", 3'd1, 3'd0, 5'd7);
      addImmediate("addi_neg", 3'd2, 3'd0, 5'b11101);
      // Distance one and two operands
      aluOp("add_fwd", `CPU_FN_ADD, 3'd3, 3'd1, 3'd2);
      aluOp("sub_fwd", `CPU_FN_SUB, 3'd4, 3'd3, 3'd1);
      aluOp("xor_fwd", `CPU_FN_XOR, 3'd5, 3'd4, 3'd1);
      aluOp("and_fwd", `CPU_FN_AND, 3'd6, 3'd5, 3'd2);
      addImmediate("addi_base", 3'd7, 3'd0, 5'd12);
      storeWord(3'd6, 3'd7, 5'd2);
      loadWord("ld_after_st", 3'd1, 3'd7, 5'd2);
      aluOp("ld_use_add", `CPU_FN_ADD, 3'd2, 3'd1, 3'd3);
      appendWord({IllegalOp, 11'd0});
      recordEvent("illegal_op", 1'b1, 3'd0, '0);
      addImmediate("after_illegal", 3'd3, 3'd2, 5'b11111);
      appendWord(NopWord);
      appendWord({`CPU_OP_HALT, 11'd0});
      // Fetched behind HALT, must never retire
      appendWord(iFormWord(`CPU_OP_ADDI, 3'd5, 3'd0, 5'd1));
      appendWord(iFormWord(`CPU_OP_ADDI, 3'd6, 3'd0, 5'd2));
   endtask

   task automatic checkIdle(input string name);
      checks++;
      if (wbValid || halted || err || imemAddr != '0) begin
         errors++;
         $display("[ERROR] %s: expected wbValid/halted/err 0/0/0 imemAddr 0000, actual %b/%b/%b %h",
                  name, wbValid, halted, err, imemAddr);
      end
   endtask

   task automatic checkEvent(input int n);
      checks++;
      if (wbValid && err) begin
         errors++;
         $display("%s: writeback and err were raised in the same cycle", expName[n]);
      end else if (expTab[n].isErr && !err) begin
         errors++;
         $display("[ERROR] %s: expected err, actual writeback r%0d=%h",
                  expName[n], wbReg, wbData);
      end else if (!expTab[n].isErr && !wbValid) begin
         errors++;
         $display("[ERROR] %s: expected r%0d=%h, actual err",
                  expName[n], expTab[n].rd, expTab[n].data);
      end else if (!expTab[n].isErr && (wbReg != expTab[n].rd || wbData != expTab[n].data)) begin
         errors++;
         $display("[ERROR] %s: expected r%0d=%h, actual r%0d=%h",
                  expName[n], expTab[n].rd, expTab[n].data, wbReg, wbData);
      end
   endtask

   initial begin
      arstN      = 1'b0;
      imemData   = NopWord;
      errors     = 0;
      checks     = 0;
      tableReady = 1'b0;
      buildProgram();
      tableReady = 1'b1;

      repeat (ResetCycles) begin
         @(negedge clk);
         checkIdle("reset");
      end
      @(posedge clk);
      arstN <= 1'b1;
      @(negedge clk);
      checkIdle("after_reset");

      // Events arrive in program order, stalls only shift them
      for (idx = 0; idx < expCount; idx++) begin
         @(negedge clk);
         while (!(wbValid || err)) begin
            @(negedge clk);
         end
         checkEvent(idx);
      end

      while (!halted) begin
         @(negedge clk);
         if (wbValid || err) begin
            errors++;
            $display("An instruction retired after the last expected one, r%0d=%h err=%b",
                     wbReg, wbData, err);
         end
      end

      addrHeld = imemAddr;
      repeat (HoldCycles) begin
         @(negedge clk);
         checks++;
         if (!halted) begin
            errors++;
            $display("halted dropped after it was raised");
         end
         if (wbValid || err) begin
            errors++;
            $display("An instruction behind HALT retired, r%0d=%h err=%b", wbReg, wbData, err);
         end
         if (imemAddr != addrHeld) begin
            errors++;
            $display("[ERROR] halt_pc: expected %h, actual %h", addrHeld, imemAddr);
         end
      end

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // Limit scales with the program plus reset, drain and hold time
   initial begin
      wait (tableReady);
      #((ResetCycles + progLen + 20 + HoldCycles) * ClkPeriod);
      $display("Watchdog expired before the program finished");
      $display("Checks run: %0d, errors: %0d", checks, errors);
      $display("Simulation failed");
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+include
rtl/cpu_pkg.sv
rtl/fetchUnit.sv
rtl/regFile.sv
rtl/decodeUnit.sv
rtl/hazardUnit.sv
rtl/executeUnit.sv
rtl/memoryUnit.sv
rtl/cpuTop.sv
bench/cpuTb.sv
